//--- image_read.f
verilog/image_read_cfg_pkg.sv
verilog/image_read_pkg.sv
verilog/image_read_geometry.sv
verilog/image_read_scan.sv
verilog/image_read_addr.sv
verilog/image_read_buffer.sv
verilog/image_read.sv
tb/image_mem_model.sv
tb/image_read_tb.sv

//--- tb/image_read_tb.sv
`timescale 1ns/100ps

module image_read_tb
    import image_read_cfg_pkg::*;
    import image_read_pkg::*;
();

    localparam int test_nb = 4;

    // name, image w h d, pad l r t b, conv side and step, beats, ready percent
    typedef struct {
        string name;
        int    img_w;
        int    img_h;
        int    img_d;
        int    pad_l;
        int    pad_r;
        int    pad_t;
        int    pad_b;
        int    conv_side;
        int    conv_step;
        int    exp_beats;
        int    ready_pct;
    } test_t;

    logic                 clk;
    logic                 rst;
    cfg_write_t           cfg_wr;
    logic                 next_req;
    logic                 next_rdy;
    rd_req_t              rd_req;
    logic [bus_width-1:0] rd_data;
    image_beat_t          image;
    logic                 image_val;
    logic                 image_rdy;

    test_t       tests [test_nb];
    image_beat_t exp_q [$];
    int          err_cnt;
    int          beat_cnt;
    int          fail_tests;
    int          cycle_cnt;
    int          cycle_limit;
    int          rd_cnt;

    image_read i_image_read (
        .clk         (clk),
        .rst         (rst),
        .cfg_i       (cfg_wr),
        .next_i      (next_req),
        .next_rdy_o  (next_rdy),
        .rd_o        (rd_req),
        .rd_data_i   (rd_data),
        .image_o     (image),
        .image_val_o (image_val),
        .image_rdy_i (image_rdy)
    );

    image_mem_model i_mem (
        .clk       (clk),
        .rd_i      (rd_req),
        .rd_data_o (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // padding pixels must never reach the memory
    always @(posedge clk) begin
        if (rd_req.valid) rd_cnt <= rd_cnt + 1;
    end

    function automatic logic [bus_width-1:0] mem_word(input int addr);
        logic [bus_width-1:0] w;
        for (int k = 0; k < group_nb; k++) begin
            w[k*img_width +: img_width] = img_width'(addr * group_nb + k);
        end
        return w;
    endfunction

    // walks origins, then conv row, conv column and depth as the scan should
    task automatic build_expected(input test_t t, output int reads);
        int          lim_w;
        int          lim_h;
        int          orow;
        int          ocol;
        int          row;
        int          col;
        int          addr;
        logic        pad;
        logic        rows_done;
        logic        cols_done;
        image_beat_t b;
        exp_q.delete();
        reads = 0;
        lim_w = t.pad_l + t.img_w + t.pad_r - t.conv_side;
        lim_h = t.pad_t + t.img_h + t.pad_b - t.conv_side;
        orow = 0;
        rows_done = 1'b0;
        while (!rows_done) begin
            ocol = 0;
            cols_done = 1'b0;
            while (!cols_done) begin
                for (int r = 0; r < t.conv_side; r++) begin
                    for (int c = 0; c < t.conv_side; c++) begin
                        for (int d = 0; d < t.img_d; d++) begin
                            row  = orow + r;
                            col  = ocol + c;
                            pad  = (col < t.pad_l) || (col >= t.pad_l + t.img_w)
                                || (row < t.pad_t) || (row >= t.pad_t + t.img_h);
                            addr = (row - t.pad_t) * t.img_w * t.img_d
                                 + (col - t.pad_l) * t.img_d + d;
                            b.bus  = pad ? '0 : mem_word(addr);
                            b.last = 1'b0;
                            exp_q.push_back(b);
                            if (!pad) reads++;
                        end
                    end
                end
                if (ocol >= lim_w) cols_done = 1'b1;
                else               ocol += t.conv_step;
            end
            if (orow >= lim_h) rows_done = 1'b1;
            else               orow += t.conv_step;
        end
        b = exp_q.pop_back();
        b.last = 1'b1;   // only the final pixel of the final window
        exp_q.push_back(b);
    endtask

    task automatic check_beat(input image_beat_t got, input image_beat_t exp, input int idx);
        beat_cnt++;
        if (got !== exp) begin
            $display("Mismatch at %0t: beat %0d got bus %h last %b, expected bus %h last %b",
                     $time, idx, got.bus, got.last, exp.bus, exp.last);
            err_cnt++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic write_cfg(input logic [cfg_awidth-1:0] addr, input cfg_word_u data);
        @(posedge clk);
        cfg_wr <= '{valid: 1'b1, addr: addr, data: data};
    endtask

    task automatic start_run();
        @(posedge clk);
        next_req <= 1'b1;
        @(posedge clk);
        check_flag(next_rdy, 1'b1, "next_rdy as start is taken");
        next_req <= 1'b0;
        @(posedge clk);
        check_flag(next_rdy, 1'b0, "next_rdy during run");
    endtask

    task automatic collect_beats(input int pct, output int got);
        image_beat_t b;
        logic        done;
        got  = 0;
        done = 1'b0;
        image_rdy <= (($urandom % 100) < pct);
        while (!done) begin
            @(posedge clk);
            if (image_val && image_rdy) begin
                b = image;
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: beat %0d has no expected value", $time, got);
                    err_cnt++;
                end else begin
                    check_beat(b, exp_q.pop_front(), got);
                end
                got++;
                done = b.last;
            end
            image_rdy <= (($urandom % 100) < pct);
        end
        repeat (10) begin
            @(posedge clk);
            if (image_val) begin
                $display("Error at %0t: a beat was offered after the last one", $time);
                err_cnt++;
            end
        end
    endtask

    task automatic run_test(input int idx);
        test_t     t;
        cfg_word_u w;
        int        err_before;
        int        got;
        int        exp_reads;
        int        rd_before;
        t = tests[idx];
        err_before = err_cnt;
        build_expected(t, exp_reads);
        check_count(exp_q.size(), t.exp_beats, "reference beat count");
        w = '0;
        w.img_w = t.img_w - 1;
        write_cfg(cfg_img_w, w);
        w = '0;
        w.dh.img_d = 16'(t.img_d - 1);
        w.dh.img_h = 16'(t.img_h - 1);
        write_cfg(cfg_img_dh, w);
        w = '0;
        w.pad.pad_l = 8'(t.pad_l);
        w.pad.pad_r = 8'(t.pad_r);
        w.pad.pad_t = 8'(t.pad_t);
        w.pad.pad_b = 8'(t.pad_b);
        write_cfg(cfg_pad, w);
        w = '0;
        w.conv.conv_side = 8'(t.conv_side - 1);
        w.conv.conv_step = 16'(t.conv_step - 1);
        write_cfg(cfg_conv, w);
        @(posedge clk);
        cfg_wr <= '0;
        rd_before = rd_cnt;
        start_run();
        collect_beats(t.ready_pct, got);
        check_count(got, t.exp_beats, "received beats");
        check_count(rd_cnt - rd_before, exp_reads, "memory reads");
        check_flag(next_rdy, 1'b1, "next_rdy after last beat");
        if (err_cnt == err_before) begin
            $display("test %0d %s: pass, %0d beats", idx, t.name, got);
        end else begin
            fail_tests++;
            $display("test %0d %s: FAIL, %0d errors", idx, t.name, err_cnt - err_before);
        end
    endtask

    initial begin
        int total;
        void'($urandom(32'ha186));
        rst        = 1'b1;
        cfg_wr     = '0;
        next_req   = 1'b0;
        image_rdy  = 1'b0;
        err_cnt    = 0;
        beat_cnt   = 0;
        fail_tests = 0;
        cycle_cnt  = 0;
        rd_cnt     = 0;
        tests[0] = '{"4x4 depth 2 1x1 no padding", 4, 4, 2, 0, 0, 0, 0, 1, 1, 32, 100};
        tests[1] = '{"3x3 conv 3 padding 1", 3, 3, 1, 1, 1, 1, 1, 3, 1, 81, 100};
        tests[2] = '{"5x5 conv 3 step 2", 5, 5, 1, 0, 0, 0, 0, 3, 2, 36, 100};
        tests[3] = '{"4x3 padded random ready", 4, 3, 2, 1, 0, 0, 1, 2, 1, 96, 50};
        total = 0;
        for (int i = 0; i < test_nb; i++) begin
            total += tests[i].exp_beats * 4 + 200;
        end
        cycle_limit = total;
        @(posedge clk);   // first reset edge, outputs still unknown before it
        repeat (4) begin
            @(posedge clk);
            check_flag(next_rdy, 1'b0, "next_rdy in reset");
        end
        rst <= 1'b0;
        @(posedge clk);
        check_flag(next_rdy, 1'b0, "next_rdy as reset ends");
        @(posedge clk);
        check_flag(next_rdy, 1'b1, "next_rdy after reset");
        for (int i = 0; i < test_nb; i++) begin
            run_test(i);
        end
        $display("tests %0d, failed %0d, beats checked %0d, errors %0d",
                 test_nb, fail_tests, beat_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb/image_mem_model.sv
`timescale 1ns/100ps

module image_mem_model
    import image_read_pkg::*;
(
    input  logic                 clk,
    input  rd_req_t              rd_i,
    output logic [bus_width-1:0] rd_data_o
);

    logic [bus_width-1:0] data_q [rd_latency];

    // lane k of word a holds a*4+k
    function automatic logic [bus_width-1:0] word_at(input logic [mem_awidth-1:0] addr);
        logic [bus_width-1:0] w;
        for (int k = 0; k < group_nb; k++) begin
            w[k*img_width +: img_width] = img_width'(int'(addr) * group_nb + k);
        end
        return w;
    endfunction

    always_ff @(posedge clk) begin
        data_q[0] <= rd_i.valid ? word_at(rd_i.addr) : '0;
        for (int i = 1; i < rd_latency; i++) begin
            data_q[i] <= data_q[i-1];   // fixed read latency
        end
    end

    assign rd_data_o = data_q[rd_latency-1];

endmodule

//--- verilog/image_read.sv
`timescale 1ns/100ps

module image_read
    import image_read_cfg_pkg::*;
    import image_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  cfg_write_t           cfg_i,
    input  logic                 next_i,
    output logic                 next_rdy_o,
    output rd_req_t              rd_o,
    input  logic [bus_width-1:0] rd_data_i,
    output image_beat_t          image_o,
    output logic                 image_val_o,
    input  logic                 image_rdy_i
);

    geometry_t   geo;
    logic        geo_valid;
    logic        run_done;
    logic        hold;      // buffer short of room for a full pipeline
    scan_pos_t   pos;
    image_beat_t beat;
    logic        push;

    image_read_geometry i_geometry (
        .clk         (clk),
        .rst         (rst),
        .cfg_i       (cfg_i),
        .next_i      (next_i),
        .next_rdy_o  (next_rdy_o),
        .run_done_i  (run_done),
        .geo_o       (geo),
        .geo_valid_o (geo_valid)
    );

    image_read_scan i_scan (
        .clk         (clk),
        .rst         (rst),
        .geo_i       (geo),
        .geo_valid_i (geo_valid),
        .hold_i      (hold),
        .pos_o       (pos),
        .run_done_o  (run_done)
    );

    image_read_addr i_addr (
        .clk       (clk),
        .rst       (rst),
        .geo_i     (geo),
        .pos_i     (pos),
        .rd_o      (rd_o),
        .rd_data_i (rd_data_i),
        .beat_o    (beat),
        .push_o    (push)
    );

    image_read_buffer i_buffer (
        .clk         (clk),
        .rst         (rst),
        .beat_i      (beat),
        .push_i      (push),
        .hold_o      (hold),
        .image_o     (image_o),
        .image_val_o (image_val_o),
        .image_rdy_i (image_rdy_i)
    );

endmodule

//--- verilog/image_read_buffer.sv
`timescale 1ns/100ps

module image_read_buffer
    import image_read_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  image_beat_t beat_i,
    input  logic        push_i,
    output logic        hold_o,
    output image_beat_t image_o,
    output logic        image_val_o,
    input  logic        image_rdy_i
);

    typedef logic [$clog2(buf_depth)-1:0]   ptr_t;
    typedef logic [$clog2(buf_depth+1)-1:0] count_t;

    image_beat_t mem_q [buf_depth];

    ptr_t   wr_ptr_q;
    ptr_t   rd_ptr_q;
    count_t count_q;
    count_t free_w;
    logic   pop;

    // room left after this cycle's push lands
    assign free_w = count_t'(buf_depth) - count_q - count_t'(push_i);
    assign hold_o = (free_w < count_t'(inflight_max));

    assign pop = (count_q != '0) & (~image_val_o | image_rdy_i);   // refill the output stage

    always_ff @(posedge clk) begin
        if (push_i) mem_q[wr_ptr_q] <= beat_i;
        if (pop)    image_o         <= mem_q[rd_ptr_q];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            image_val_o <= 1'b0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)    rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            if (~image_val_o | image_rdy_i) begin
                image_val_o <= (count_q != '0);
            end
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        image_val_o && !image_rdy_i |=> image_val_o && $stable(image_o))
        else $error("output beat changed while stalled");

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push_i |-> count_q < count_t'(buf_depth))
        else $error("push into a full buffer");

endmodule

//--- verilog/image_read_addr.sv
`timescale 1ns/100ps

module image_read_addr
    import image_read_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  geometry_t            geo_i,
    input  scan_pos_t            pos_i,
    output rd_req_t              rd_o,
    input  logic [bus_width-1:0] rd_data_i,
    output image_beat_t          beat_o,
    output logic                 push_o
);

    dim_t row_1p;      // row and column inside the unpadded image
    dim_t col_1p;
    dim_t dpt_1p;
    dim_t prod_h_2p;
    dim_t prod_w_2p;
    dim_t dpt_2p;
    dim_t sum_hw_3p;
    dim_t dpt_3p;
    dim_t addr_4p;

    logic val_1p;
    logic val_2p;
    logic val_3p;
    logic val_4p;
    logic last_1p;
    logic last_2p;
    logic last_3p;
    logic last_4p;
    logic pad_1p;
    logic pad_2p;
    logic pad_3p;
    logic pad_4p;

    // flags waiting for the memory to answer
    logic [rd_latency-1:0] val_p;
    logic [rd_latency-1:0] last_p;
    logic [rd_latency-1:0] pad_p;

    always_ff @(posedge clk) begin
        row_1p  <= pos_i.row - geo_i.pad_t;
        col_1p  <= pos_i.col - geo_i.pad_l;
        dpt_1p  <= pos_i.depth;
        last_1p <= pos_i.last;
        pad_1p  <= (pos_i.col < geo_i.edge_l) | (pos_i.col > geo_i.edge_r)
                 | (pos_i.row < geo_i.edge_t) | (pos_i.row > geo_i.edge_b);

        prod_h_2p <= row_1p * geo_i.plane;
        prod_w_2p <= col_1p * geo_i.img_d;
        dpt_2p    <= dpt_1p;
        last_2p   <= last_1p;
        pad_2p    <= pad_1p;

        sum_hw_3p <= prod_h_2p + prod_w_2p;
        dpt_3p    <= dpt_2p;
        last_3p   <= last_2p;
        pad_3p    <= pad_2p;

        addr_4p <= sum_hw_3p + dpt_3p;
        last_4p <= last_3p;
        pad_4p  <= pad_3p;

        last_p <= {last_p[rd_latency-2:0], last_4p};
        pad_p  <= {pad_p[rd_latency-2:0], pad_4p};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            val_1p <= 1'b0;
            val_2p <= 1'b0;
            val_3p <= 1'b0;
            val_4p <= 1'b0;
            val_p  <= '0;
            push_o <= 1'b0;
        end else begin
            val_1p <= pos_i.valid;
            val_2p <= val_1p;
            val_3p <= val_2p;
            val_4p <= val_3p;
            val_p  <= {val_p[rd_latency-2:0], val_4p};
            push_o <= val_p[rd_latency-1];
        end
    end

    // padding pixels skip the memory
    assign rd_o = '{valid: val_4p & ~pad_4p, addr: addr_4p[mem_awidth-1:0]};

    always_ff @(posedge clk) begin
        beat_o.bus  <= pad_p[rd_latency-1] ? '0 : rd_data_i;
        beat_o.last <= last_p[rd_latency-1];
    end

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        rd_o.valid |-> addr_4p < (dim_t'(1) << mem_awidth))
        else $error("read address 0x%0h outside image memory", addr_4p);

endmodule

//--- verilog/image_read_scan.sv
`timescale 1ns/100ps

module image_read_scan
    import image_read_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  geometry_t geo_i,
    input  logic      geo_valid_i,
    input  logic      hold_i,
    output scan_pos_t pos_o,
    output logic      run_done_o
);

    logic [st_num-1:0] state_q;
    logic [st_num-1:0] state_nx;

    dim_t area_h_cnt_q;   // window origin row
    dim_t area_w_cnt_q;   // window origin column
    dim_t conv_h_cnt_q;   // offsets inside the window
    dim_t conv_w_cnt_q;
    dim_t conv_d_cnt_q;

    logic area_h_last;
    logic area_w_last;
    logic conv_h_last;
    logic conv_w_last;
    logic conv_d_last;
    logic pos_last;
    logic emit;

    assign area_h_last = (area_h_cnt_q >= geo_i.area_h_max);
    assign area_w_last = (area_w_cnt_q >= geo_i.area_w_max);
    assign conv_h_last = (conv_h_cnt_q >= geo_i.conv_max);
    assign conv_w_last = (conv_w_cnt_q >= geo_i.conv_max);
    assign conv_d_last = (conv_d_cnt_q >= geo_i.img_d - 1'b1);

    assign pos_last = area_h_last & area_w_last & conv_h_last & conv_w_last & conv_d_last;

    // the buffer only asks for a pause when it cannot take a full pipeline
    assign emit = state_q[st_active] & ~hold_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q          <= '0;
            state_q[st_idle] <= 1'b1;
        end else begin
            state_q <= state_nx;
        end
    end

    always_comb begin
        state_nx = '0;
        case (1'b1)
            state_q[st_idle]: begin
                if (geo_valid_i) state_nx[st_active] = 1'b1;
                else             state_nx[st_idle]   = 1'b1;
            end
            state_q[st_active]: begin
                if (emit && pos_last) state_nx[st_idle]   = 1'b1;
                else if (hold_i)      state_nx[st_paused] = 1'b1;
                else                  state_nx[st_active] = 1'b1;
            end
            state_q[st_paused]: begin
                if (!hold_i) state_nx[st_active] = 1'b1;
                else         state_nx[st_paused] = 1'b1;
            end
            default: begin
                state_nx[st_idle] = 1'b1;
            end
        endcase
    end

    // depth runs fastest, then conv column, conv row, origin column, origin row
    always_ff @(posedge clk) begin
        if (rst || state_q[st_idle]) begin
            area_h_cnt_q <= '0;
            area_w_cnt_q <= '0;
            conv_h_cnt_q <= '0;
            conv_w_cnt_q <= '0;
            conv_d_cnt_q <= '0;
        end else if (emit) begin
            conv_d_cnt_q <= conv_d_cnt_q + 1'b1;
            if (conv_d_last) begin
                conv_d_cnt_q <= '0;
                conv_w_cnt_q <= conv_w_cnt_q + 1'b1;
                if (conv_w_last) begin
                    conv_w_cnt_q <= '0;
                    conv_h_cnt_q <= conv_h_cnt_q + 1'b1;
                    if (conv_h_last) begin
                        conv_h_cnt_q <= '0;
                        area_w_cnt_q <= area_w_cnt_q + geo_i.conv_step;
                        if (area_w_last) begin
                            area_w_cnt_q <= '0;
                            area_h_cnt_q <= area_h_cnt_q + geo_i.conv_step;
                            if (area_h_last) begin
                                area_h_cnt_q <= '0;
                            end
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        pos_o.valid = emit;
        pos_o.last  = emit & pos_last;
        pos_o.row   = area_h_cnt_q + conv_h_cnt_q;
        pos_o.col   = area_w_cnt_q + conv_w_cnt_q;
        pos_o.depth = conv_d_cnt_q;
    end

    assign run_done_o = emit & pos_last;

endmodule

//--- verilog/image_read_geometry.sv
`timescale 1ns/100ps

module image_read_geometry
    import image_read_cfg_pkg::*;
    import image_read_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cfg_write_t cfg_i,
    input  logic       next_i,
    output logic       next_rdy_o,
    input  logic       run_done_i,
    output geometry_t  geo_o,
    output logic       geo_valid_o
);

    cfg_word_u reg_img_w_q;
    cfg_word_u reg_dh_q;
    cfg_word_u reg_pad_q;
    cfg_word_u reg_conv_q;

    logic start;
    logic rst_q;
    logic run_active_q;
    logic start_1p;
    logic start_2p;

    dim_t img_w_1p;
    dim_t img_h_1p;
    dim_t img_d_1p;
    dim_t pad_l_1p;
    dim_t pad_r_1p;
    dim_t pad_t_1p;
    dim_t pad_b_1p;
    dim_t conv_side_1p;
    dim_t conv_step_1p;
    dim_t area_w_2p;   // padded area
    dim_t area_h_2p;

    assign start = next_i & next_rdy_o;

    always_ff @(posedge clk) begin
        if (cfg_i.valid && cfg_i.addr == cfg_img_w) reg_img_w_q <= cfg_i.data;
        if (cfg_i.valid && cfg_i.addr == cfg_img_dh) reg_dh_q <= cfg_i.data;
        if (cfg_i.valid && cfg_i.addr == cfg_pad) reg_pad_q <= cfg_i.data;
        if (cfg_i.valid && cfg_i.addr == cfg_conv) reg_conv_q <= cfg_i.data;
    end

    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            next_rdy_o   <= 1'b0;
            run_active_q <= 1'b0;
            start_1p     <= 1'b0;
            start_2p     <= 1'b0;
            geo_valid_o  <= 1'b0;
        end else begin
            start_1p    <= start;
            start_2p    <= start_1p;
            geo_valid_o <= start_2p;
            if (rst_q || run_done_i) begin
                next_rdy_o <= 1'b1;     // ready again once the scan finishes
            end else if (start) begin
                next_rdy_o <= 1'b0;
            end
            if (start) begin
                run_active_q <= 1'b1;
            end else if (run_done_i) begin
                run_active_q <= 1'b0;
            end
        end
    end

    // sizes are stored minus one, padding is stored as is
    always_ff @(posedge clk) begin
        if (start) begin
            img_w_1p     <= reg_img_w_q.img_w + 1'b1;
            img_h_1p     <= dim_t'(reg_dh_q.dh.img_h) + 1'b1;
            img_d_1p     <= dim_t'(reg_dh_q.dh.img_d) + 1'b1;
            pad_l_1p     <= dim_t'(reg_pad_q.pad.pad_l);
            pad_r_1p     <= dim_t'(reg_pad_q.pad.pad_r);
            pad_t_1p     <= dim_t'(reg_pad_q.pad.pad_t);
            pad_b_1p     <= dim_t'(reg_pad_q.pad.pad_b);
            conv_side_1p <= dim_t'(reg_conv_q.conv.conv_side) + 1'b1;
            conv_step_1p <= dim_t'(reg_conv_q.conv.conv_step) + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        area_w_2p        <= pad_l_1p + img_w_1p + pad_r_1p;
        area_h_2p        <= pad_t_1p + img_h_1p + pad_b_1p;
        geo_o.img_w      <= img_w_1p;
        geo_o.img_h      <= img_h_1p;
        geo_o.img_d      <= img_d_1p;
        geo_o.pad_l      <= pad_l_1p;
        geo_o.pad_t      <= pad_t_1p;
        geo_o.edge_l     <= pad_l_1p;
        geo_o.edge_r     <= pad_l_1p + img_w_1p - 1'b1;
        geo_o.edge_t     <= pad_t_1p;
        geo_o.edge_b     <= pad_t_1p + img_h_1p - 1'b1;
        geo_o.conv_max   <= conv_side_1p - 1'b1;
        geo_o.conv_step  <= conv_step_1p;
        geo_o.plane      <= img_w_1p * img_d_1p;
        // third stage, needs the padded area from the cycle before
        geo_o.area_w_max <= area_w_2p - conv_side_1p;
        geo_o.area_h_max <= area_h_2p - conv_side_1p;
    end

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !run_active_q)
        else $error("start taken while a scan is still running");

endmodule

//--- verilog/image_read_pkg.sv
package image_read_pkg;

    localparam int mem_awidth   = 16;
    localparam int group_nb     = 4;
    localparam int img_width    = 16;
    localparam int bus_width    = group_nb * img_width;   // 64
    localparam int rd_latency   = 3;
    localparam int buf_depth    = 16;
    localparam int inflight_max = 8;   // scan to buffer pipeline depth

    // one-hot scan states
    localparam int st_idle   = 0;
    localparam int st_active = 1;
    localparam int st_paused = 2;
    localparam int st_num    = 3;

    typedef logic [31:0] dim_t;

    typedef struct packed {
        dim_t img_w;
        dim_t img_h;
        dim_t img_d;
        dim_t pad_l;
        dim_t pad_t;
        dim_t edge_l;      // first image column inside the padded area
        dim_t edge_r;      // last image column
        dim_t edge_t;
        dim_t edge_b;
        dim_t area_w_max;  // window origins stop at or above these
        dim_t area_h_max;
        dim_t conv_max;    // conv side minus one
        dim_t conv_step;
        dim_t plane;       // width times depth
    } geometry_t;

    typedef struct packed {
        logic valid;
        logic last;
        dim_t row;
        dim_t col;
        dim_t depth;
    } scan_pos_t;

    typedef struct packed {
        logic                  valid;
        logic [mem_awidth-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic [bus_width-1:0] bus;
        logic                 last;
    } image_beat_t;

endpackage

//--- verilog/image_read_cfg_pkg.sv
package image_read_cfg_pkg;

    localparam int cfg_dwidth = 32;
    localparam int cfg_awidth = 5;

    localparam int cfg_half_w = 16;   // depth, height and step fields
    localparam int cfg_byte_w = 8;    // padding and conv side fields

    // register map of the write port
    localparam logic [cfg_awidth-1:0] cfg_img_w  = 5'd0;
    localparam logic [cfg_awidth-1:0] cfg_img_dh = 5'd1;
    localparam logic [cfg_awidth-1:0] cfg_pad    = 5'd2;
    localparam logic [cfg_awidth-1:0] cfg_conv   = 5'd3;

    typedef struct packed {
        logic [cfg_half_w-1:0] img_d;
        logic [cfg_half_w-1:0] img_h;
    } cfg_dh_t;

    typedef struct packed {
        logic [cfg_byte_w-1:0] pad_l;
        logic [cfg_byte_w-1:0] pad_r;
        logic [cfg_byte_w-1:0] pad_t;
        logic [cfg_byte_w-1:0] pad_b;
    } cfg_pads_t;

    typedef struct packed {
        logic [cfg_byte_w-1:0] rsvd;        // ignored
        logic [cfg_byte_w-1:0] conv_side;
        logic [cfg_half_w-1:0] conv_step;
    } cfg_conv_t;

    // one data word, read differently depending on the register it lands in
    typedef union packed {
        logic [cfg_dwidth-1:0] img_w;
        cfg_dh_t               dh;
        cfg_pads_t             pad;
        cfg_conv_t             conv;
    } cfg_word_u;

    typedef struct packed {
        logic                  valid;
        logic [cfg_awidth-1:0] addr;
        cfg_word_u             data;
    } cfg_write_t;

endpackage
